/* build.f */
common/bam_cfg_pkg.sv
common/bam_tlp_pkg.sv
rtl/bam_fifo.sv
rtl/bam_beat_counter.sv
rtl/bam_cpl_hdr.sv
rtl/bam_ctrl_fsm.sv
rtl/bam_top.sv
tb/bam_tb.sv

/* common/bam_cfg_pkg.sv */
/*
  Datapath sizing of the bridge. One dword per beat, dword aligned addresses.
  MAX_LEN bounds both the Avalon burst and the completion, with no splitting.
*/
package bam_cfg_pkg;

  // ------------------------------------------------------------
  // Datapath widths
  // ------------------------------------------------------------
  localparam int DATA_W = 32;  // One dword per beat
  localparam int ADDR_W = 32;  // Avalon byte address

  // ------------------------------------------------------------
  // Request length limits
  // ------------------------------------------------------------
  localparam int MAX_LEN = 16;                  // Longest burst in dwords
  localparam int LEN_W   = $clog2(MAX_LEN + 1); // Holds 0..MAX_LEN

  // ------------------------------------------------------------
  // Buffer depths
  // ------------------------------------------------------------
  localparam int RX_DEPTH = 32;      // Receive beats queued ahead of the FSM
  localparam int RD_DEPTH = MAX_LEN; // One full read burst

  // Payload dword
  typedef logic [DATA_W-1:0] dword_t;

  // Dword count, also used as Avalon burstcount
  typedef logic [LEN_W-1:0] len_t;

endpackage

/* common/bam_tlp_pkg.sv */
/*
  Simplified request and completion header layouts, 64 bits each.
  Lengths are in dwords and must lie in 1..MAX_LEN.
*/
package bam_tlp_pkg;

  // Request kind, carried in the header MSB
  typedef enum logic [0:0] {
    REQ_WR = 1'b0,  // Posted memory write
    REQ_RD = 1'b1   // Memory read, needs a completion
  } req_kind_t;

  // Request header, rides on the sop beat
  typedef struct packed {
    req_kind_t                        kind;
    bam_cfg_pkg::len_t                length;       // Dwords
    logic [7:0]                       tag;
    logic [15:0]                      requester_id;
    logic [bam_cfg_pkg::ADDR_W-1:0]   address;      // Byte address, dword aligned
    logic [1:0]                       rsvd;
  } req_hdr_t;

  // Completion-with-data header
  typedef struct packed {
    logic [15:0]       completer_id;
    logic [15:0]       requester_id;
    logic [7:0]        tag;
    bam_cfg_pkg::len_t length;
    logic [6:0]        byte_count;   // Length in bytes, at most 64
    logic [6:0]        lower_addr;   // Low address bits of the request
    logic [2:0]        status;
    logic [1:0]        rsvd;
  } cpl_hdr_t;

  // ------------------------------------------------------------
  // Completion status codes
  // ------------------------------------------------------------
  localparam logic [2:0] CPL_SC = 3'd0;  // Successful completion

  // One receive stream beat as stored in the receive FIFO
  typedef struct packed {
    req_hdr_t            hdr;   // Valid on sop only
    bam_cfg_pkg::dword_t data;  // Ignored for reads
    logic                sop;
    logic                eop;
  } rx_beat_t;

endpackage

/* rtl/bam_beat_counter.sv */
/*
  Dwords left in the current write burst, read burst or completion.
  Load wins over decrement. Decrement at zero is ignored.
*/
`timescale 1ns/1ns

module bam_beat_counter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load_i,
  input  bam_cfg_pkg::len_t load_len_i,
  input  logic              dec_i,
  output logic              zero_o
);

  bam_cfg_pkg::len_t count;

  assign zero_o = (count == '0);  // Straight from the register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load_i) begin
      count <= load_len_i;
    end else if (dec_i && !zero_o) begin
      count <= count - 1'b1;
    end
  end

endmodule

/* rtl/bam_cpl_hdr.sv */
/*
  Completion header builder. Fields are taken from the read request on capture
  and hold until the next capture. Completer ID is passed through live.
*/
`timescale 1ns/1ns

module bam_cpl_hdr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  capture_i,
  input  bam_tlp_pkg::req_hdr_t req_hdr_i,
  input  logic [15:0]           completer_id_i,
  output bam_tlp_pkg::cpl_hdr_t cpl_hdr_o
);

  logic [7:0]        tag_q;
  logic [15:0]       req_id_q;
  bam_cfg_pkg::len_t len_q;
  logic [6:0]        low_addr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_q      <= '0;
      req_id_q   <= '0;
      len_q      <= '0;
      low_addr_q <= '0;
    end else if (capture_i) begin
      tag_q      <= req_hdr_i.tag;
      req_id_q   <= req_hdr_i.requester_id;
      len_q      <= req_hdr_i.length;
      low_addr_q <= req_hdr_i.address[6:0];
    end
  end

  // ------------------------------------------------------------
  // Header assembly
  // ------------------------------------------------------------
  always_comb begin
    cpl_hdr_o              = '0;       // Reserved bits stay zero
    cpl_hdr_o.completer_id = completer_id_i;
    cpl_hdr_o.requester_id = req_id_q;
    cpl_hdr_o.tag          = tag_q;
    cpl_hdr_o.length       = len_q;
    cpl_hdr_o.byte_count   = {len_q, 2'b00};  // Dwords to bytes
    cpl_hdr_o.lower_addr   = low_addr_q;
    cpl_hdr_o.status       = bam_tlp_pkg::CPL_SC;
  end

endmodule

/* rtl/bam_ctrl_fsm.sv */
/*
  One request at a time, in arrival order. Write data comes straight from the
  receive FIFO head, so avm_write_o drops while the next dword is missing.
*/
`timescale 1ns/1ns

module bam_ctrl_fsm (
  input  logic                           clk,
  input  logic                           rst_n,
  input  bam_tlp_pkg::rx_beat_t          rx_head_i,
  input  logic                           rx_empty_i,
  input  logic                           rd_empty_i,
  input  logic                           cnt_zero_i,
  input  logic                           avm_waitrequest_i,
  input  logic                           avm_readdatavalid_i,
  input  logic                           tx_ready_i,
  output logic                           rx_pop_o,
  output logic                           rd_push_o,
  output logic                           rd_pop_o,
  output logic                           cnt_load_o,
  output bam_cfg_pkg::len_t              cnt_len_o,
  output logic                           cnt_dec_o,
  output logic                           hdr_capture_o,
  output logic [bam_cfg_pkg::ADDR_W-1:0] avm_address_o,
  output logic                           avm_write_o,
  output bam_cfg_pkg::dword_t            avm_writedata_o,
  output logic                           avm_read_o,
  output bam_cfg_pkg::len_t              avm_burstcount_o,
  output logic                           tx_valid_o,
  output logic                           tx_sop_o,
  output logic                           tx_eop_o
);

  typedef enum logic [2:0] {
    IDLE,
    WR_BURST,
    RD_CMD,
    RD_DATA,
    CPL_TX
  } state_t;

  state_t                         state_q;
  state_t                         state_d;
  logic [bam_cfg_pkg::ADDR_W-1:0] addr_q;      // Burst address
  bam_cfg_pkg::len_t              burst_q;     // Burst length, also completion length
  logic                           sop_pend_q;  // First completion beat not yet sent
  logic                           head_sop;    // Request header waiting at FIFO head
  logic                           is_rd;
  logic                           wr_take;     // Write beat accepted by slave
  logic                           tx_take;     // Completion beat transferred

  assign head_sop = !rx_empty_i && rx_head_i.sop;
  assign is_rd    = (rx_head_i.hdr.kind == bam_tlp_pkg::REQ_RD);

  // ------------------------------------------------------------
  // Avalon master
  // ------------------------------------------------------------
  assign avm_address_o    = addr_q;
  assign avm_burstcount_o = burst_q;
  assign avm_writedata_o  = rx_head_i.data;
  assign avm_write_o      = (state_q == WR_BURST) && !rx_empty_i && !cnt_zero_i;
  assign avm_read_o       = (state_q == RD_CMD);
  assign wr_take          = avm_write_o && !avm_waitrequest_i;

  // Transmit stream, data is the read FIFO head
  assign tx_valid_o = (state_q == CPL_TX) && !rd_empty_i;
  assign tx_sop_o   = tx_valid_o && sop_pend_q;
  assign tx_eop_o   = tx_valid_o && cnt_zero_i;  // Count was reloaded with length - 1
  assign tx_take    = tx_valid_o && tx_ready_i;

  // FIFO control
  assign rd_push_o = (state_q == RD_DATA) && avm_readdatavalid_i && !cnt_zero_i;
  assign rd_pop_o  = tx_take;
  // Read header beat is consumed in IDLE, stray non-sop beats are flushed
  assign rx_pop_o  = wr_take ||
                     ((state_q == IDLE) && !rx_empty_i && (!rx_head_i.sop || is_rd));

  assign hdr_capture_o = (state_q == IDLE) && head_sop && is_rd;

  // Counter control
  assign cnt_load_o = ((state_q == IDLE) && head_sop) ||
                      ((state_q == RD_DATA) && cnt_zero_i);
  assign cnt_len_o  = (state_q == IDLE) ? rx_head_i.hdr.length : burst_q - 1'b1;
  assign cnt_dec_o  = wr_take || rd_push_o || (tx_take && !cnt_zero_i);

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (head_sop) state_d = is_rd ? RD_CMD : WR_BURST;
      WR_BURST: if (cnt_zero_i) state_d = IDLE;          // Last beat taken
      RD_CMD:   if (!avm_waitrequest_i) state_d = RD_DATA;
      RD_DATA:  if (cnt_zero_i) state_d = CPL_TX;        // All dwords buffered
      CPL_TX:   if (tx_take && cnt_zero_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      sop_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == RD_DATA) && cnt_zero_i) begin
        sop_pend_q <= 1'b1;  // Entering CPL_TX
      end else if (tx_take) begin
        sop_pend_q <= 1'b0;
      end
    end
  end

  // Command registers, loaded when a request is decoded
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && head_sop) begin
      addr_q  <= rx_head_i.hdr.address;
      burst_q <= rx_head_i.hdr.length;
    end
  end

endmodule

/* rtl/bam_fifo.sv */
/*
  Synchronous show-ahead FIFO, entry visible one cycle after its push.
  Push to full and pop from empty are dropped. DEPTH must be 2 or more.
*/
`timescale 1ns/1ns

module bam_fifo #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 16
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push_i,
  input  entry_t push_data_i,
  input  logic   pop_i,
  output entry_t head_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t             mem [DEPTH];  // Storage, no reset
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;        // Occupancy
  logic               do_push;
  logic               do_pop;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;   // Drop on full
  assign do_pop  = pop_i && !empty_o;   // Drop on empty
  assign head_o  = mem[rd_ptr];         // Show-ahead head

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

/* rtl/bam_top.sv */
/*
  Request stream to bursting Avalon-MM bridge. Writes are posted, reads return
  one completion of at most MAX_LEN dwords. Requests run strictly in order.
*/
`timescale 1ns/1ns

module bam_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [15:0]                    completer_id_i,
  // Receive stream
  input  logic                           rx_valid_i,
  input  logic                           rx_sop_i,
  input  logic                           rx_eop_i,
  input  bam_tlp_pkg::req_hdr_t          rx_hdr_i,
  input  bam_cfg_pkg::dword_t            rx_data_i,
  output logic                           rx_ready_o,
  // Avalon-MM master
  output logic [bam_cfg_pkg::ADDR_W-1:0] avm_address_o,
  output logic                           avm_write_o,
  output bam_cfg_pkg::dword_t            avm_writedata_o,
  output logic                           avm_read_o,
  output bam_cfg_pkg::len_t              avm_burstcount_o,
  input  logic                           avm_waitrequest_i,
  input  bam_cfg_pkg::dword_t            avm_readdata_i,
  input  logic                           avm_readdatavalid_i,
  // Transmit stream
  output logic                           tx_valid_o,
  output logic                           tx_sop_o,
  output logic                           tx_eop_o,
  output bam_tlp_pkg::cpl_hdr_t          tx_hdr_o,
  output bam_cfg_pkg::dword_t            tx_data_o,
  input  logic                           tx_ready_i
);

  bam_tlp_pkg::rx_beat_t rx_beat;   // Incoming beat as stored
  bam_tlp_pkg::rx_beat_t rx_head;
  logic                  rx_full;
  logic                  rx_empty;
  logic                  rx_pop;
  logic                  rd_empty;
  logic                  rd_push;
  logic                  rd_pop;
  logic                  cnt_load;
  bam_cfg_pkg::len_t     cnt_len;
  logic                  cnt_dec;
  logic                  cnt_zero;
  logic                  hdr_capture;

  assign rx_beat    = '{hdr: rx_hdr_i, data: rx_data_i, sop: rx_sop_i, eop: rx_eop_i};
  assign rx_ready_o = !rx_full;

  // ------------------------------------------------------------
  // Buffers
  // ------------------------------------------------------------
  bam_fifo #(
    .entry_t (bam_tlp_pkg::rx_beat_t),
    .DEPTH   (bam_cfg_pkg::RX_DEPTH)
  ) rx_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (rx_valid_i && rx_ready_o),  // Beat transfers on valid and ready
    .push_data_i (rx_beat),
    .pop_i       (rx_pop),
    .head_o      (rx_head),
    .full_o      (rx_full),
    .empty_o     (rx_empty)
  );

  bam_fifo #(
    .entry_t (bam_cfg_pkg::dword_t),
    .DEPTH   (bam_cfg_pkg::RD_DEPTH)
  ) rd_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (rd_push),
    .push_data_i (avm_readdata_i),
    .pop_i       (rd_pop),
    .head_o      (tx_data_o),  // Completion payload
    .full_o      (),           // Sized for one burst
    .empty_o     (rd_empty)
  );

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  bam_ctrl_fsm u_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .rx_head_i           (rx_head),
    .rx_empty_i          (rx_empty),
    .rd_empty_i          (rd_empty),
    .cnt_zero_i          (cnt_zero),
    .avm_waitrequest_i   (avm_waitrequest_i),
    .avm_readdatavalid_i (avm_readdatavalid_i),
    .tx_ready_i          (tx_ready_i),
    .rx_pop_o            (rx_pop),
    .rd_push_o           (rd_push),
    .rd_pop_o            (rd_pop),
    .cnt_load_o          (cnt_load),
    .cnt_len_o           (cnt_len),
    .cnt_dec_o           (cnt_dec),
    .hdr_capture_o       (hdr_capture),
    .avm_address_o       (avm_address_o),
    .avm_write_o         (avm_write_o),
    .avm_writedata_o     (avm_writedata_o),
    .avm_read_o          (avm_read_o),
    .avm_burstcount_o    (avm_burstcount_o),
    .tx_valid_o          (tx_valid_o),
    .tx_sop_o            (tx_sop_o),
    .tx_eop_o            (tx_eop_o)
  );

  bam_beat_counter u_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (cnt_load),
    .load_len_i (cnt_len),
    .dec_i      (cnt_dec),
    .zero_o     (cnt_zero)
  );

  bam_cpl_hdr u_cpl_hdr (
    .clk            (clk),
    .rst_n          (rst_n),
    .capture_i      (hdr_capture),
    .req_hdr_i      (rx_head.hdr),
    .completer_id_i (completer_id_i),
    .cpl_hdr_o      (tx_hdr_o)
  );

endmodule

/* tb/bam_cases.txt */
// kind(0 write, 1 read) address length tag requester_id first_dword, all hex
// write beat k carries first_dword + k, first_dword unused for reads
0 00001000 04 01 0100 a0000000
1 00001000 04 02 0100 00000000
1 00002000 01 03 0101 00000000
0 00002004 10 04 0102 b0000000
1 00002000 10 05 0102 00000000
0 00003040 01 06 0103 c0000000
1 00003040 01 07 0103 00000000
0 00001008 02 08 0104 d0000000
1 00001000 04 09 0104 00000000
1 0000407c 07 0a 0105 00000000
0 00005000 10 0b 0106 e0000000
0 00005020 08 0c 0106 f0000000
1 00005000 10 0d 0106 00000000
1 00006000 10 0e 0107 00000000
1 00006010 03 0f 0107 00000000
0 00000000 03 10 0108 12340000
1 00000000 05 11 0108 00000000
0 00007ff0 10 12 0109 55aa0000

/* tb/bam_tb.sv */
/*
  Drives tb/bam_cases.txt through the bridge with a random-stall Avalon slave.
  Must run from the project root. Unwritten slave addresses read back as the address.
*/
`timescale 1ns/1ns

module bam_tb;

  localparam int          CLK_HALF = 50;        // 100 ns period
  localparam logic [15:0] CPL_ID   = 16'h0a51;  // Completer ID under test

  logic                           clk;
  logic                           rst_n;
  logic [15:0]                    completer_id_i;
  logic                           rx_valid_i;
  logic                           rx_sop_i;
  logic                           rx_eop_i;
  bam_tlp_pkg::req_hdr_t          rx_hdr_i;
  bam_cfg_pkg::dword_t            rx_data_i;
  logic                           rx_ready_o;
  logic [bam_cfg_pkg::ADDR_W-1:0] avm_address_o;
  logic                           avm_write_o;
  bam_cfg_pkg::dword_t            avm_writedata_o;
  logic                           avm_read_o;
  bam_cfg_pkg::len_t              avm_burstcount_o;
  logic                           avm_waitrequest_i;
  bam_cfg_pkg::dword_t            avm_readdata_i;
  logic                           avm_readdatavalid_i;
  logic                           tx_valid_o;
  logic                           tx_sop_o;
  logic                           tx_eop_o;
  bam_tlp_pkg::cpl_hdr_t          tx_hdr_o;
  bam_cfg_pkg::dword_t            tx_data_o;
  logic                           tx_ready_i;

  // Case table, one entry per file line
  logic                  case_rd[$];
  logic [31:0]           case_addr[$];
  int                    case_len[$];
  logic [7:0]            case_tag[$];
  logic [15:0]           case_rid[$];
  logic [31:0]           case_first[$];
  int                    n_cases;
  logic                  cases_loaded;

  bam_cfg_pkg::dword_t   mem[logic [31:0]];      // Slave memory
  bam_cfg_pkg::dword_t   ref_mem[logic [31:0]];  // Writes applied in case order
  bam_cfg_pkg::dword_t   exp_q[$];               // Completion dwords in order

  int                    errors;
  int                    chk_idx;   // Case now on the Avalon or tx side
  int                    wr_beat;
  int                    tx_beat;
  int                    rd_left;   // Read dwords still to return
  logic [31:0]           rd_addr;
  logic                  stall_q;   // Tx beat held last edge
  logic                  sop_q;
  logic                  eop_q;
  bam_cfg_pkg::dword_t   data_q;
  bam_tlp_pkg::cpl_hdr_t hdr_q;

  bam_top dut (.*);

  always #CLK_HALF clk = ~clk;

  // ------------------------------------------------------------
  // Case file and reference model
  // ------------------------------------------------------------
  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] k, a, l, t, r, d;
    fd = $fopen("tb/bam_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/bam_cases.txt");
      $display("Test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h %h", k, a, l, t, r, d);
        if (n == 6) begin  // Comment and blank lines skipped
          case_rd.push_back(k[0]);
          case_addr.push_back(a);
          case_len.push_back(int'(l));
          case_tag.push_back(t[7:0]);
          case_rid.push_back(r[15:0]);
          case_first.push_back(d);
        end
      end
      $fclose(fd);
      n_cases = case_rd.size();
    end
  endtask

  task automatic build_expected();
    logic [31:0] a;
    for (int i = 0; i < n_cases; i++) begin
      for (int k = 0; k < case_len[i]; k++) begin
        a = case_addr[i] + 32'(4 * k);
        if (case_rd[i]) begin
          exp_q.push_back(ref_mem.exists(a) ? ref_mem[a] : a);
        end else begin
          ref_mem[a] = case_first[i] + 32'(k);
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // Receive stream driver
  // ------------------------------------------------------------
  task automatic send_case(input int i);
    bam_tlp_pkg::req_hdr_t hdr;
    int                    beats;
    hdr              = '0;
    hdr.kind         = case_rd[i] ? bam_tlp_pkg::REQ_RD : bam_tlp_pkg::REQ_WR;
    hdr.length       = bam_cfg_pkg::len_t'(case_len[i]);
    hdr.tag          = case_tag[i];
    hdr.requester_id = case_rid[i];
    hdr.address      = case_addr[i];
    beats            = case_rd[i] ? 1 : case_len[i];  // Read is a lone header beat
    for (int k = 0; k < beats; k++) begin
      rx_valid_i <= 1'b1;
      rx_sop_i   <= (k == 0);
      rx_eop_i   <= (k == beats - 1);
      rx_hdr_i   <= hdr;
      rx_data_i  <= case_rd[i] ? 32'h0 : case_first[i] + 32'(k);
      do @(posedge clk); while (!rx_ready_o);  // Hold until taken
    end
  endtask

  task automatic check_idle(input string when);
    if (avm_write_o !== 1'b0 || avm_read_o !== 1'b0 || tx_valid_o !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: %s write %b read %b tx_valid %b", $time, when,
               avm_write_o, avm_read_o, tx_valid_o);
    end
  endtask

  // ------------------------------------------------------------
  // Avalon side checks
  // ------------------------------------------------------------
  task automatic take_write();
    if (chk_idx >= n_cases || case_rd[chk_idx]) begin
      errors++;
      $display("unexpected Avalon write beat at %0t while case %0d runs", $time, chk_idx);
    end else begin
      if (avm_address_o !== case_addr[chk_idx] ||
          avm_burstcount_o !== bam_cfg_pkg::len_t'(case_len[chk_idx])) begin
        errors++;
        $display("mismatch at %0t: write command %h/%0d", $time, avm_address_o,
                 avm_burstcount_o);
      end
      if (avm_writedata_o !== case_first[chk_idx] + 32'(wr_beat)) begin
        errors++;
        $display("mismatch at %0t: write beat %0d got %h expected %h", $time, wr_beat,
                 avm_writedata_o, case_first[chk_idx] + 32'(wr_beat));
      end
    end
    mem[avm_address_o + 32'(4 * wr_beat)] = avm_writedata_o;  // Slave steps its address
    wr_beat++;
    if (wr_beat == int'(avm_burstcount_o)) begin
      $display("case %0d write %h len %0d done, errors %0d", chk_idx, avm_address_o,
               wr_beat, errors);
      wr_beat = 0;
      chk_idx++;
    end
  endtask

  task automatic take_read_cmd();
    if (chk_idx >= n_cases || !case_rd[chk_idx]) begin
      errors++;
      $display("unexpected Avalon read command at %0t while case %0d runs", $time, chk_idx);
    end else if (avm_address_o !== case_addr[chk_idx] ||
                 avm_burstcount_o !== bam_cfg_pkg::len_t'(case_len[chk_idx])) begin
      errors++;
      $display("mismatch at %0t: read command %h/%0d", $time, avm_address_o,
               avm_burstcount_o);
    end
    rd_addr = avm_address_o;
    rd_left = int'(avm_burstcount_o);
  endtask

  // ------------------------------------------------------------
  // Completion checks
  // ------------------------------------------------------------
  task automatic take_tx_beat();
    bam_cfg_pkg::dword_t want;
    int                  i;
    i = chk_idx;
    tx_beat++;
    if (i >= n_cases || !case_rd[i]) begin
      errors++;
      $display("unexpected completion beat at %0t while case %0d runs", $time, i);
    end else begin
      if (tx_sop_o !== (tx_beat == 1) || tx_eop_o !== (tx_beat == case_len[i])) begin
        errors++;
        $display("mismatch at %0t: beat %0d sop %b eop %b", $time, tx_beat, tx_sop_o,
                 tx_eop_o);
      end
      if (tx_beat == 1 && (tx_hdr_o.tag !== case_tag[i] ||
          tx_hdr_o.requester_id !== case_rid[i] ||
          tx_hdr_o.length !== bam_cfg_pkg::len_t'(case_len[i]) ||
          tx_hdr_o.byte_count !== 7'(4 * case_len[i]) ||
          tx_hdr_o.lower_addr !== case_addr[i][6:0] ||
          tx_hdr_o.status !== bam_tlp_pkg::CPL_SC ||
          tx_hdr_o.completer_id !== CPL_ID)) begin
        errors++;
        $display("mismatch at %0t: case %0d completion header %h", $time, i, tx_hdr_o);
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("completion beat at %0t has no expected dword left", $time);
      end else begin
        want = exp_q.pop_front();
        if (tx_data_o !== want) begin
          errors++;
          $display("mismatch at %0t: case %0d dword %0d got %h expected %h", $time, i,
                   tx_beat, tx_data_o, want);
        end
      end
      if (tx_beat == case_len[i]) begin
        $display("case %0d read %h len %0d done, errors %0d", i, case_addr[i],
                 case_len[i], errors);
        tx_beat = 0;
        chk_idx++;
      end
    end
  endtask

  // Slave model and stream monitor, all sampled on the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      avm_readdatavalid_i <= 1'b0;
      rd_left = 0;
      wr_beat = 0;
      tx_beat = 0;
      stall_q = 1'b0;
    end else begin
      if (avm_write_o && !avm_waitrequest_i) take_write();
      if (avm_read_o && !avm_waitrequest_i) take_read_cmd();
      if (stall_q && (tx_valid_o !== 1'b1 || tx_sop_o !== sop_q || tx_eop_o !== eop_q ||
                      tx_data_o !== data_q || tx_hdr_o !== hdr_q)) begin
        errors++;
        $display("mismatch at %0t: transmit beat changed while stalled", $time);
      end
      if (tx_valid_o && tx_ready_i) take_tx_beat();
      stall_q = tx_valid_o && !tx_ready_i;
      sop_q   = tx_sop_o;
      eop_q   = tx_eop_o;
      data_q  = tx_data_o;
      hdr_q   = tx_hdr_o;
      if (rd_left > 0 && ($urandom % 4) != 0) begin  // Gaps in read return
        avm_readdatavalid_i <= 1'b1;
        avm_readdata_i      <= mem.exists(rd_addr) ? mem[rd_addr] : rd_addr;
        rd_addr = rd_addr + 32'd4;
        rd_left--;
      end else begin
        avm_readdatavalid_i <= 1'b0;
      end
    end
    avm_waitrequest_i <= (($urandom % 4) == 0);
    tx_ready_i        <= (($urandom % 4) != 0);
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    cases_loaded        = 1'b0;
    clk                 = 1'b0;
    rst_n               = 1'b0;
    rx_valid_i          = 1'b0;
    rx_sop_i            = 1'b0;
    rx_eop_i            = 1'b0;
    rx_hdr_i            = '0;
    rx_data_i           = '0;
    avm_waitrequest_i   = 1'b0;
    avm_readdata_i      = '0;
    avm_readdatavalid_i = 1'b0;
    tx_ready_i          = 1'b0;
    completer_id_i      = CPL_ID;
    errors              = 0;
    chk_idx             = 0;
    void'($urandom(1));  // Single seed for the run
    read_cases();
    build_expected();
    cases_loaded = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i > 0) check_idle("during reset");  // First edge still shows X state
    end
    rst_n <= 1'b1;
    repeat (2) begin
      @(posedge clk);
      check_idle("after reset");
    end
    for (int i = 0; i < n_cases; i++) begin
      send_case(i);  // Back to back
    end
    rx_valid_i <= 1'b0;
    rx_sop_i   <= 1'b0;
    rx_eop_i   <= 1'b0;
    wait (chk_idx >= n_cases);
    if (mem.size() != ref_mem.size()) begin
      errors++;
      $display("mismatch at %0t: slave memory holds %0d written dwords, %0d expected",
               $time, mem.size(), ref_mem.size());
    end
    foreach (ref_mem[a]) begin
      if ((mem.exists(a) ? mem[a] : a) !== ref_mem[a]) begin
        errors++;
        $display("mismatch at %0t: memory %h expected %h", $time, a, ref_mem[a]);
      end
    end
    $display("%0d of %0d cases finished, %0d errors", chk_idx, n_cases, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, scaled by case count and longest burst
  initial begin
    wait (cases_loaded === 1'b1);
    repeat (n_cases * bam_cfg_pkg::MAX_LEN * 40) @(posedge clk);
    $display("timeout: only %0d of %0d cases finished in time", chk_idx, n_cases);
    $display("Test failed");
    $finish;
  end

endmodule
